// ==== Makefile ====
# Verilator build and run for the frame loopback testbench

VERILATOR ?= verilator
TOP ?= eth_frame_loop_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/eth_frame_loop.sv ====
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module eth_frame_loop (
	input logic clk,
	input logic rst_n,
	input logic [7:0] in_data,
	input logic in_last,
	input logic in_user,
	input logic in_valid,
	output logic in_ready,
	output logic [7:0] out_data,
	output logic out_user,
	output logic out_last,
	output logic out_valid,
	input logic out_ready
);
	import eth_frame_pkg::*;
	import loop_ctl_pkg::*;

	frame_beat_t rx_beat;
	logic rx_beat_valid;
	logic rx_beat_ready;
	frame_beat_t tx_beat;
	logic tx_beat_valid;
	logic tx_beat_ready;

	loop_ctl_t rx_ctl;
	logic rx_ctl_valid;
	logic rx_ctl_ready;
	loop_ctl_t tx_ctl;
	logic tx_ctl_valid;
	logic tx_ctl_ready;

	eth_frame_loop_rx u_rx (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(in_data),
		.in_last(in_last),
		.in_user(in_user),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.beat(rx_beat),
		.beat_valid(rx_beat_valid),
		.beat_ready(rx_beat_ready),
		.ctl(rx_ctl),
		.ctl_valid(rx_ctl_valid),
		.ctl_ready(rx_ctl_ready)
	);

	// Frame bytes
	loop_fifo #(
		.WIDTH($bits(frame_beat_t)),
		.AW(`FRAME_FIFO_AW)
	) u_frame_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_data(rx_beat),
		.wr_valid(rx_beat_valid),
		.wr_ready(rx_beat_ready),
		.rd_data(tx_beat),
		.rd_valid(tx_beat_valid),
		.rd_ready(tx_beat_ready)
	);

	// One control word per frame
	loop_fifo #(
		.WIDTH($bits(loop_ctl_t)),
		.AW(`CTL_FIFO_AW)
	) u_ctl_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_data(rx_ctl),
		.wr_valid(rx_ctl_valid),
		.wr_ready(rx_ctl_ready),
		.rd_data(tx_ctl),
		.rd_valid(tx_ctl_valid),
		.rd_ready(tx_ctl_ready)
	);

	eth_frame_loop_tx u_tx (
		.clk(clk),
		.rst_n(rst_n),
		.frame(tx_beat),
		.frame_valid(tx_beat_valid),
		.frame_ready(tx_beat_ready),
		.ctl(tx_ctl),
		.ctl_valid(tx_ctl_valid),
		.ctl_ready(tx_ctl_ready),
		.out_data(out_data),
		.out_user(out_user),
		.out_last(out_last),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

// ==== source/eth_frame_loop_rx.sv ====
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module eth_frame_loop_rx (
	input logic clk,
	input logic rst_n,
	input logic [7:0] in_data,
	input logic in_last,
	input logic in_user,
	input logic in_valid,
	output logic in_ready,
	output eth_frame_pkg::frame_beat_t beat,
	output logic beat_valid,
	input logic beat_ready,
	output loop_ctl_pkg::loop_ctl_t ctl,
	output logic ctl_valid,
	input logic ctl_ready
);
	import eth_frame_pkg::*;
	import loop_ctl_pkg::*;

	// Pseudo-header protocol term is constant, so the UDP sum starts with it
	localparam logic [16:0] UDP_ACC_INIT = {9'd0, IP_PROTO_UDP};
	// Word index of the UDP checksum minus twice the IHL
	localparam logic [13:0] TR_POS_BASE = 14'((ETH_HDR_LEN + UDP_CSUM_OFS) >> 1);

	rx_state_t state;
	logic [15:0] cnt;
	logic [15:0] eth_type;
	logic [3:0] ihl;
	logic [7:0] proto;
	logic [16:0] ip_acc;
	logic [16:0] udp_acc;
	logic fcs_bad;

	logic accept;
	logic [15:0] ip_end;
	logic [15:0] udp_rel;
	logic in_ip_hdr;
	logic in_ip_addr;
	logic in_udp;
	logic [15:0] byte_word;
	logic [15:0] udp_word;
	logic is_udp;

	function automatic logic [16:0] csum_add(input logic [16:0] acc, input logic [15:0] word);
		return {1'b0, acc[15:0]} + {16'd0, acc[16]} + {1'b0, word};
	endfunction

	function automatic logic [15:0] csum_final(input logic [16:0] acc);
		logic [16:0] folded;
		logic [15:0] result;
		folded = {1'b0, acc[15:0]} + {16'd0, acc[16]};
		result = ~(folded[15:0] + {15'd0, folded[16]});
		// Zero would mean "no checksum" to tx
		return (result == 16'd0) ? 16'hffff : result;
	endfunction

	assign in_ready = beat_ready && (state != RX_WRITE_CTL);
	assign beat_valid = in_valid && (state != RX_WRITE_CTL);
	assign beat = '{data: in_data, last: in_last};
	assign accept = in_valid && in_ready;

	// Position logic
	assign ip_end = ETH_HDR_LEN + {10'd0, ihl, 2'b00};
	assign udp_rel = cnt - ip_end;
	// IHL is not latched yet on its own byte, so byte 14 is forced in
	assign in_ip_hdr = ((cnt == ETH_HDR_LEN) || (cnt > ETH_HDR_LEN && cnt < ip_end))
		&& (cnt[15:1] != IP_CSUM_WORD);
	assign in_ip_addr = (cnt >= IP_ADDR_OFS) && (cnt < IP_ADDR_OFS + IP_ADDR_LEN);
	assign in_udp = (cnt > ETH_HDR_LEN) && (cnt >= ip_end)
		&& (udp_rel[15:1] != UDP_CSUM_OFS[15:1]);

	// Even offsets are the high byte of a word, so an odd tail byte is zero padded
	assign byte_word = cnt[0] ? {8'd0, in_data} : {in_data, 8'd0};

	// UDP length counts twice, once in the header and once in the pseudo-header;
	// doubling in ones' complement is a left rotate
	assign udp_word = (in_udp && udp_rel[15:1] == UDP_LEN_OFS[15:1])
		? {byte_word[14:0], byte_word[15]} : byte_word;

	always_ff @(posedge clk) begin
		if (accept) begin
			if (cnt == ETHERTYPE_OFS)
				eth_type[15:8] <= in_data;
			if (cnt == ETHERTYPE_OFS + 16'd1)
				eth_type[7:0] <= in_data;
			if (cnt == ETH_HDR_LEN)
				ihl <= in_data[3:0];
			if (cnt == IP_PROTO_OFS)
				proto <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= RX_HEADER;
			cnt <= 16'd0;
			ip_acc <= 17'd0;
			udp_acc <= UDP_ACC_INIT;
			fcs_bad <= 1'b0;
		end else begin
			case (state)
				RX_WRITE_CTL: begin
					if (ctl_ready) begin
						state <= RX_HEADER;
						cnt <= 16'd0;
						ip_acc <= 17'd0;
						udp_acc <= UDP_ACC_INIT;
					end
				end
				default: begin
					if (accept) begin
						cnt <= cnt + 16'd1;
						if (state == RX_BODY && in_ip_hdr)
							ip_acc <= csum_add(ip_acc, byte_word);
						if (state == RX_BODY && (in_ip_addr || in_udp))
							udp_acc <= csum_add(udp_acc, udp_word);

						if (in_last) begin
							state <= RX_WRITE_CTL;
							fcs_bad <= in_user;
						end else if (state == RX_HEADER && cnt == ETHERTYPE_OFS + 16'd1) begin
							// Non-IPv4 frames are only forwarded to the FIFO, then dropped
							if ({eth_type[15:8], in_data} == ETHERTYPE_IPV4)
								state <= RX_BODY;
							else
								state <= RX_DROP_REST;
						end
					end
				end
			endcase
		end
	end

	// cnt holds the frame length while the control word is presented
	assign is_udp = (proto == IP_PROTO_UDP) && (cnt >= ip_end + UDP_HDR_LEN);
	assign ctl_valid = (state == RX_WRITE_CTL);

	always_comb begin
		ctl.ip_csum = csum_final(ip_acc);
		ctl.tr_csum = is_udp ? csum_final(udp_acc) : 16'd0;
		ctl.tr_csum_pos = TR_POS_BASE + {9'd0, ihl, 1'b0};
		ctl.drop_frame = (eth_type != ETHERTYPE_IPV4) || (cnt < 16'(`MIN_FRAME_LEN))
			|| (cnt < ip_end);
		ctl.fcs_invalid = fcs_bad;
	end

endmodule

`default_nettype wire

// ==== source/eth_frame_loop_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_frame_loop_tx (
	input logic clk,
	input logic rst_n,
	input eth_frame_pkg::frame_beat_t frame,
	input logic frame_valid,
	output logic frame_ready,
	input loop_ctl_pkg::loop_ctl_t ctl,
	input logic ctl_valid,
	output logic ctl_ready,
	output logic [7:0] out_data,
	output logic out_user,
	output logic out_last,
	output logic out_valid,
	input logic out_ready
);
	import eth_frame_pkg::*;
	import loop_ctl_pkg::*;

	tx_state_t state;
	logic [15:0] count;
	logic [15:0] ip_csum;
	logic [15:0] tr_csum;
	logic [13:0] tr_csum_pos;
	logic fcs_invalid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= TX_WAIT_CTL;
			count <= 16'd0;
			ip_csum <= 16'd0;
			tr_csum <= 16'd0;
			tr_csum_pos <= 14'd0;
			fcs_invalid <= 1'b0;
			ctl_ready <= 1'b0;
		end else begin
			case (state)
				TX_WAIT_CTL: begin
					ctl_ready <= 1'b1;
					if (ctl_ready && ctl_valid) begin
						state <= ctl.drop_frame ? TX_DROP_FRAME : TX_FRAME;
						count <= 16'd0;
						ip_csum <= ctl.ip_csum;
						tr_csum <= ctl.tr_csum;
						tr_csum_pos <= ctl.tr_csum_pos;
						fcs_invalid <= ctl.fcs_invalid;
						// Drop ready right away so only one word is taken per frame
						ctl_ready <= 1'b0;
					end
				end
				TX_FRAME: begin
					if (out_ready && out_valid) begin
						count <= count + 16'd1;
						if (out_last)
							state <= TX_WAIT_CTL;
					end
				end
				TX_DROP_FRAME: begin
					if (frame_ready && frame_valid && frame.last)
						state <= TX_WAIT_CTL;
				end
				default: begin
					state <= TX_WAIT_CTL;
				end
			endcase
		end
	end

	// Pass-through with checksum substitution, high byte first
	always_comb begin
		out_data = 8'd0;
		out_last = 1'b0;
		out_user = 1'b0;
		out_valid = 1'b0;
		frame_ready = 1'b0;

		if (state == TX_FRAME) begin
			if (ip_csum != 16'd0 && count[15:1] == IP_CSUM_WORD)
				out_data = count[0] ? ip_csum[7:0] : ip_csum[15:8];
			else if (tr_csum != 16'd0 && count[15:1] == {1'b0, tr_csum_pos})
				out_data = count[0] ? tr_csum[7:0] : tr_csum[15:8];
			else
				out_data = frame.data;

			out_last = frame.last;
			out_user = fcs_invalid && frame.last;
			out_valid = frame_valid;
			frame_ready = out_ready;
		end else if (state == TX_DROP_FRAME) begin
			frame_ready = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/eth_frame_pkg.sv ====
`default_nettype none

package eth_frame_pkg;

	// One byte of the frame stream
	typedef struct packed {
		logic [7:0] data;
		logic last;
	} frame_beat_t;

	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam logic [7:0] IP_PROTO_UDP = 8'd17;

	// Byte offsets from the start of the frame
	localparam logic [15:0] ETHERTYPE_OFS = 16'd12;
	localparam logic [15:0] ETH_HDR_LEN = 16'd14;
	localparam logic [15:0] IP_PROTO_OFS = 16'd23;
	localparam logic [15:0] IP_ADDR_OFS = 16'd26;
	localparam logic [15:0] IP_ADDR_LEN = 16'd8;
	// 16-bit word index of the IP header checksum
	localparam logic [14:0] IP_CSUM_WORD = 15'd12;

	// Byte offsets inside the UDP header
	localparam logic [15:0] UDP_LEN_OFS = 16'd4;
	localparam logic [15:0] UDP_CSUM_OFS = 16'd6;
	localparam logic [15:0] UDP_HDR_LEN = 16'd8;

endpackage

`default_nettype wire

// ==== source/eth_loop_settings.svh ====
`ifndef ETH_LOOP_SETTINGS_SVH
`define ETH_LOOP_SETTINGS_SVH
`default_nettype none

// Frame FIFO holds one full frame plus margin
`define FRAME_FIFO_AW 11
`define CTL_FIFO_AW 2
// Shortest frame that still holds a basic IPv4 header
`define MIN_FRAME_LEN 34

`default_nettype wire
`endif

// ==== source/loop_ctl_pkg.sv ====
`default_nettype none

package loop_ctl_pkg;

	// One control word per frame, passed from rx to tx
	typedef struct packed {
		logic [15:0] ip_csum;
		logic [15:0] tr_csum;
		logic [13:0] tr_csum_pos;
		logic drop_frame;
		logic fcs_invalid;
	} loop_ctl_t;

	typedef enum logic [1:0] {
		RX_HEADER,
		RX_BODY,
		RX_DROP_REST,
		RX_WRITE_CTL
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_WAIT_CTL,
		TX_FRAME,
		TX_DROP_FRAME
	} tx_state_t;

endpackage

`default_nettype wire

// ==== source/loop_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module loop_fifo #(
	parameter int WIDTH = 8,
	parameter int AW = 4
) (
	input logic clk,
	input logic rst_n,
	input logic [WIDTH-1:0] wr_data,
	input logic wr_valid,
	output logic wr_ready,
	output logic [WIDTH-1:0] rd_data,
	output logic rd_valid,
	input logic rd_ready
);
	localparam logic [AW:0] DEPTH = (AW + 1)'(1 << AW);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic [AW:0] count_next;
	logic wr_fire;
	logic rd_fire;
	logic full_next;
	logic empty_next;

	assign wr_fire = wr_valid && wr_ready;
	assign rd_fire = rd_valid && rd_ready;
	assign count_next = count + {{AW{1'b0}}, wr_fire} - {{AW{1'b0}}, rd_fire};
	assign full_next = (count_next == DEPTH);
	assign empty_next = (count_next == '0);

	// Combinational read of the head entry
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_fire)
			mem[wr_ptr] <= wr_data;
	end

	// Flags are registered, so a write shows on the read side one cycle later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr_ready <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			if (wr_fire)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_fire)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			wr_ready <= !full_next;
			rd_valid <= !empty_next;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/eth_frame_loop_checker.sv ====
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module eth_frame_loop_checker (
	input logic clk,
	input logic rst_n,
	input logic [7:0] in_data,
	input logic in_last,
	input logic in_user,
	input logic in_valid,
	input logic in_ready,
	input logic [7:0] out_data,
	input logic out_user,
	input logic out_last,
	input logic out_valid,
	input logic out_ready,
	input logic end_of_test,
	output int frames_checked,
	output int frames_dropped,
	output int error_count
);
	import eth_frame_pkg::*;

	logic [7:0] in_bytes [$];
	int in_lens [$];
	logic in_fcs [$];
	logic [7:0] out_bytes [$];
	logic out_users [$];
	logic [7:0] exp_frame [0:2047];
	int cur_len;
	int frame_idx;
	bit flushed;

	// Big-endian 16-bit words from first up to stop, an odd tail byte padded with zero
	function automatic logic [31:0] add_words(input int first, input int stop, input int skip);
		logic [31:0] sum;
		logic [7:0] low;
		int i;
		sum = 32'd0;
		for (i = first; i < stop; i += 2) begin
			low = (i + 1 < stop) ? exp_frame[i + 1] : 8'd0;
			if (i != skip)
				sum = sum + {16'd0, exp_frame[i], low};
		end
		return sum;
	endfunction

	function automatic logic [15:0] finish_sum(input logic [31:0] sum);
		logic [31:0] folded;
		logic [15:0] csum;
		folded = sum;
		while (folded[31:16] != 16'd0)
			folded = {16'd0, folded[15:0]} + {16'd0, folded[31:16]};
		csum = ~folded[15:0];
		return (csum == 16'd0) ? 16'hffff : csum;
	endfunction

	function automatic int ip_hdr_end();
		return int'(ETH_HDR_LEN) + 4 * int'(exp_frame[14][3:0]);
	endfunction

	function automatic logic frame_dropped(input int len);
		if (len < `MIN_FRAME_LEN)
			return 1'b1;
		if ({exp_frame[12], exp_frame[13]} != ETHERTYPE_IPV4)
			return 1'b1;
		return len < ip_hdr_end();
	endfunction

	// Overwrites both checksum fields of exp_frame with freshly computed values
	task automatic patch_frame(input int len);
		int ip_end;
		int csum_ofs;
		logic [31:0] sum;
		logic [15:0] ip_csum;
		logic [15:0] udp_csum;
		ip_end = ip_hdr_end();
		csum_ofs = 2 * int'(IP_CSUM_WORD);
		ip_csum = finish_sum(add_words(int'(ETH_HDR_LEN), ip_end, csum_ofs));
		// Protocol at IP offset 9, addresses at IP offsets 12 to 19
		if (exp_frame[int'(ETH_HDR_LEN) + 9] == IP_PROTO_UDP && len >= ip_end + 8) begin
			sum = add_words(int'(ETH_HDR_LEN) + 12, int'(ETH_HDR_LEN) + 20, -1);
			sum = sum + {24'd0, IP_PROTO_UDP} + {16'd0, exp_frame[ip_end + 4], exp_frame[ip_end + 5]};
			sum = sum + add_words(ip_end, len, ip_end + 6);
			udp_csum = finish_sum(sum);
			exp_frame[ip_end + 6] = udp_csum[15:8];
			exp_frame[ip_end + 7] = udp_csum[7:0];
		end
		exp_frame[csum_ofs] = ip_csum[15:8];
		exp_frame[csum_ofs + 1] = ip_csum[7:0];
	endtask

	// Pops input frames until one that must come out, reporting drops on the way
	task automatic next_input(output logic found, output int len, output logic fcs);
		int i;
		found = 1'b0;
		len = 0;
		fcs = 1'b0;
		while (!found && in_lens.size() > 0) begin
			len = in_lens.pop_front();
			fcs = in_fcs.pop_front();
			for (i = 0; i < len; i++)
				exp_frame[i] = in_bytes.pop_front();
			frame_idx++;
			if (frame_dropped(len)) begin
				frames_dropped++;
				$display("Frame %0d: %0d bytes dropped, no output", frame_idx, len);
			end else begin
				found = 1'b1;
			end
		end
	endtask

	task automatic compare_frame();
		logic found;
		logic fcs;
		logic exp_user;
		int len;
		int errs;
		int n;
		int i;
		next_input(found, len, fcs);
		if (!found) begin
			error_count++;
			$display("Error: an output frame of %0d bytes has no input frame left to match it",
				out_bytes.size());
		end else begin
			patch_frame(len);
			errs = 0;
			n = (out_bytes.size() < len) ? out_bytes.size() : len;
			if (out_bytes.size() != len) begin
				errs++;
				$display("mismatch at %0t: frame %0d has %0d bytes, expected %0d",
					$time, frame_idx, out_bytes.size(), len);
			end
			for (i = 0; i < n; i++) begin
				exp_user = fcs && (i == len - 1);
				if (out_bytes[i] !== exp_frame[i]) begin
					errs++;
					$display("mismatch at %0t: frame %0d byte %0d is %h, expected %h",
						$time, frame_idx, i, out_bytes[i], exp_frame[i]);
				end
				if (out_users[i] !== exp_user) begin
					errs++;
					$display("mismatch at %0t: frame %0d byte %0d out_user is %b, expected %b",
						$time, frame_idx, i, out_users[i], exp_user);
				end
			end
			frames_checked++;
			error_count += errs;
			if (errs == 0)
				$display("Frame %0d: %0d bytes ok", frame_idx, len);
			else
				$display("Frame %0d: %0d errors", frame_idx, errs);
		end
		out_bytes.delete();
		out_users.delete();
	endtask

	// Whatever is still queued at the end should have been dropped
	task automatic flush_inputs();
		logic found;
		logic fcs;
		int len;
		next_input(found, len, fcs);
		while (found) begin
			error_count++;
			$display("Error: frame %0d of %0d bytes was sent but never came out", frame_idx, len);
			next_input(found, len, fcs);
		end
		if (out_bytes.size() != 0) begin
			error_count++;
			$display("Error: output stopped in the middle of a frame after %0d bytes",
				out_bytes.size());
		end
	endtask

	// Sampled on the falling edge, half a cycle away from every change
	always @(negedge clk) begin
		if (!rst_n) begin
			cur_len = 0;
		end else begin
			if (in_valid && in_ready) begin
				in_bytes.push_back(in_data);
				cur_len++;
				if (in_last) begin
					in_lens.push_back(cur_len);
					in_fcs.push_back(in_user);
					cur_len = 0;
				end
			end
			if (out_valid && out_ready) begin
				out_bytes.push_back(out_data);
				out_users.push_back(out_user);
				if (out_last)
					compare_frame();
			end
			if (end_of_test && !flushed) begin
				flushed = 1'b1;
				flush_inputs();
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/eth_frame_loop_tb.sv ====
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module eth_frame_loop_tb;
	import eth_frame_pkg::*;

	localparam logic [31:0] LCG_SEED = 32'ha069_9f7d;
	localparam int NUM_CASES = 14;

	localparam logic [1:0] KIND_UDP = 2'd0;
	// IPv4 carrying TCP
	localparam logic [1:0] KIND_OTHER = 2'd1;
	// ARP ethertype
	localparam logic [1:0] KIND_NON_IP = 2'd2;

	localparam logic [1:0] READY_ALWAYS = 2'd0;
	localparam logic [1:0] READY_ALTERNATE = 2'd1;
	localparam logic [1:0] READY_RANDOM = 2'd2;

	typedef struct packed {
		logic [1:0] kind;
		logic [11:0] len;
		logic [3:0] ihl;
		logic [7:0] seed;
		logic bad_fcs;
		logic [1:0] ready_mode;
	} frame_case_t;

	localparam frame_case_t CASES [NUM_CASES] = '{
		// kind, length, IHL, payload seed, bad FCS, out_ready pattern
		'{KIND_UDP, 12'd60, 4'd5, 8'h01, 1'b0, READY_ALWAYS},
		'{KIND_UDP, 12'd64, 4'd6, 8'h02, 1'b0, READY_ALWAYS},
		'{KIND_UDP, 12'd61, 4'd5, 8'h03, 1'b0, READY_ALTERNATE},
		'{KIND_OTHER, 12'd70, 4'd5, 8'h04, 1'b0, READY_ALWAYS},
		'{KIND_NON_IP, 12'd64, 4'd5, 8'h05, 1'b0, READY_ALWAYS},
		'{KIND_UDP, 12'd30, 4'd5, 8'h06, 1'b0, READY_ALWAYS},
		'{KIND_UDP, 12'd80, 4'd5, 8'h07, 1'b1, READY_ALWAYS},
		'{KIND_OTHER, 12'd40, 4'd15, 8'h08, 1'b0, READY_RANDOM},
		'{KIND_UDP, 12'd100, 4'd7, 8'h09, 1'b0, READY_RANDOM},
		'{KIND_UDP, 12'd75, 4'd6, 8'h0a, 1'b1, READY_RANDOM},
		'{KIND_OTHER, 12'd50, 4'd8, 8'h0b, 1'b1, READY_RANDOM},
		'{KIND_NON_IP, 12'd40, 4'd5, 8'h0c, 1'b0, READY_RANDOM},
		'{KIND_UDP, 12'd128, 4'd5, 8'h0d, 1'b0, READY_RANDOM},
		'{KIND_UDP, 12'd45, 4'd5, 8'h0e, 1'b0, READY_ALTERNATE}
	};

	logic clk;
	logic rst_n;
	logic [7:0] in_data;
	logic in_last;
	logic in_user;
	logic in_valid;
	logic in_ready;
	logic [7:0] out_data;
	logic out_user;
	logic out_last;
	logic out_valid;
	logic out_ready;
	logic end_of_test;
	int frames_checked;
	int frames_dropped;
	int error_count;

	logic [1:0] ready_mode;
	logic [31:0] payload_state;
	logic [31:0] ready_state;
	logic [7:0] frame_buf [0:2047];

	eth_frame_loop UUT (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(in_data),
		.in_last(in_last),
		.in_user(in_user),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_data(out_data),
		.out_user(out_user),
		.out_last(out_last),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	eth_frame_loop_checker u_checker (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(in_data),
		.in_last(in_last),
		.in_user(in_user),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_data(out_data),
		.out_user(out_user),
		.out_last(out_last),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.end_of_test(end_of_test),
		.frames_checked(frames_checked),
		.frames_dropped(frames_dropped),
		.error_count(error_count)
	);

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int total_bytes();
		int sum;
		int i;
		sum = 0;
		for (i = 0; i < NUM_CASES; i++)
			sum += int'(CASES[i].len);
		return sum;
	endfunction

	function automatic logic frame_kept(input frame_case_t tc);
		return (tc.kind != KIND_NON_IP) && (int'(tc.len) >= `MIN_FRAME_LEN)
			&& (int'(tc.len) >= int'(ETH_HDR_LEN) + 4 * int'(tc.ihl));
	endfunction

	// Random bytes everywhere, then the header fields the DUT looks at
	task automatic build_frame(input frame_case_t tc);
		int i;
		int ip_end;
		logic [15:0] ethertype;
		logic [15:0] ip_len;
		logic [15:0] udp_len;
		payload_state = LCG_SEED ^ {24'd0, tc.seed};
		for (i = 0; i < int'(tc.len); i++) begin
			payload_state = next_random(payload_state);
			frame_buf[i] = payload_state[31:24];
		end
		ip_end = int'(ETH_HDR_LEN) + 4 * int'(tc.ihl);
		ethertype = (tc.kind == KIND_NON_IP) ? 16'h0806 : ETHERTYPE_IPV4;
		ip_len = 16'(int'(tc.len) - int'(ETH_HDR_LEN));
		frame_buf[12] = ethertype[15:8];
		frame_buf[13] = ethertype[7:0];
		frame_buf[14] = {4'h4, tc.ihl};
		frame_buf[16] = ip_len[15:8];
		frame_buf[17] = ip_len[7:0];
		frame_buf[23] = (tc.kind == KIND_UDP) ? IP_PROTO_UDP : 8'd6;
		// Stale checksums that the DUT has to replace
		frame_buf[24] = 8'hde;
		frame_buf[25] = 8'had;
		if (tc.kind == KIND_UDP) begin
			udp_len = 16'(int'(tc.len) - ip_end);
			frame_buf[ip_end + 4] = udp_len[15:8];
			frame_buf[ip_end + 5] = udp_len[7:0];
			frame_buf[ip_end + 6] = 8'hbe;
			frame_buf[ip_end + 7] = 8'hef;
		end
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic send_beat(input logic [7:0] data, input logic last, input logic user);
		logic done;
		in_data = data;
		in_last = last;
		in_user = user;
		in_valid = 1'b1;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done = in_ready;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_frame(input int len, input logic bad_fcs);
		int i;
		for (i = 0; i < len; i++)
			send_beat(frame_buf[i], i == len - 1, bad_fcs && (i == len - 1));
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		out_ready = 1'b1;
		ready_state = LCG_SEED;
		forever begin
			@(posedge clk);
			#1;
			ready_state = next_random(ready_state);
			case (ready_mode)
				READY_ALTERNATE: out_ready = !out_ready;
				READY_RANDOM: out_ready = ready_state[31];
				default: out_ready = 1'b1;
			endcase
		end
	end

	initial begin
		int limit;
		limit = total_bytes() * 20 + 1000;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int i;
		int expected_out;
		rst_n = 1'b0;
		in_data = 8'd0;
		in_last = 1'b0;
		in_user = 1'b0;
		in_valid = 1'b0;
		end_of_test = 1'b0;
		ready_mode = READY_ALWAYS;
		payload_state = LCG_SEED;
		expected_out = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (i = 0; i < NUM_CASES; i++) begin
			ready_mode = CASES[i].ready_mode;
			build_frame(CASES[i]);
			send_frame(int'(CASES[i].len), CASES[i].bad_fcs);
			if (frame_kept(CASES[i]))
				expected_out++;
		end
		in_valid = 1'b0;
		in_last = 1'b0;
		in_user = 1'b0;

		wait (frames_checked >= expected_out);
		// Idle time so that an extra frame would still show up
		repeat (50) @(posedge clk);
		end_of_test = 1'b1;
		repeat (3) @(posedge clk);

		$display("Frames checked %0d, dropped %0d, errors %0d",
			frames_checked, frames_dropped, error_count);
		if (error_count == 0 && frames_checked == expected_out
			&& frames_dropped == NUM_CASES - expected_out)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/eth_frame_pkg.sv
source/loop_ctl_pkg.sv
source/loop_fifo.sv
source/eth_frame_loop_rx.sv
source/eth_frame_loop_tx.sv
source/eth_frame_loop.sv
testbench/eth_frame_loop_checker.sv
testbench/eth_frame_loop_tb.sv
